//--- source/riscv_mem_pkg.sv
package riscv_mem_pkg;

  // widths that carry a meaning
  typedef logic [63:0] dm_addr_t;  // only the low bits select a byte
  typedef logic [63:0] dm_data_t;
  typedef logic [7:0]  dm_byte_t;
  typedef logic [1:0]  dm_size_t;  // log2 of access bytes
  typedef logic [2:0]  mem_funct3_t;

  // access size codes
  localparam dm_size_t DM_SIZE_B = 2'd0;
  localparam dm_size_t DM_SIZE_H = 2'd1;
  localparam dm_size_t DM_SIZE_W = 2'd2;
  localparam dm_size_t DM_SIZE_D = 2'd3;

  // bit 2 of funct3 marks zero extension
  localparam mem_funct3_t F3_B  = 3'd0;
  localparam mem_funct3_t F3_H  = 3'd1;
  localparam mem_funct3_t F3_W  = 3'd2;
  localparam mem_funct3_t F3_D  = 3'd3;
  localparam mem_funct3_t F3_BU = 3'd4;
  localparam mem_funct3_t F3_HU = 3'd5;
  localparam mem_funct3_t F3_WU = 3'd6;

  localparam int DM_BYTES      = 32;
  localparam int DM_IDX_W      = 5;
  localparam int DM_WORD_BYTES = 8;   // bytes in one dm_data_t

  localparam int REQ_FIFO_DEPTH = 4;  // also the credit count after reset
  localparam int CREDIT_W       = 3;
  localparam int FIFO_PTR_W     = $clog2(REQ_FIFO_DEPTH);

  typedef enum logic {
    CTRL_IDLE,
    CTRL_ACCESS
  } ctrl_state_t;

endpackage

//--- source/riscv_lsu_req.sv
`timescale 1ns/1ns

module riscv_lsu_req
  import riscv_mem_pkg::*;
(
  input  logic        i_riscv_dm_rst,
  input  logic        i_riscv_dm_clk_n,
  input  logic        i_req_valid,
  input  logic        i_req_store,
  input  mem_funct3_t i_req_funct3,
  input  dm_addr_t    i_req_addr,
  input  dm_data_t    i_req_wdata,
  input  logic        i_credit,
  output logic        o_req_ready,
  output logic        o_push,
  output logic        o_push_store,
  output dm_size_t    o_push_size,
  output logic        o_push_unsigned,
  output dm_addr_t    o_push_addr,
  output dm_data_t    o_push_wdata
);

  logic [CREDIT_W-1:0] credits;
  logic                accept;

  assign o_req_ready = (credits != '0);  // room left in the fifo
  assign accept      = i_req_valid && o_req_ready;

  // decoded request goes straight to the fifo
  assign o_push          = accept;
  assign o_push_store    = i_req_store;
  assign o_push_size     = dm_size_t'(i_req_funct3[1:0]);
  assign o_push_unsigned = i_req_funct3[2] && !i_req_store;  // stores ignore bit 2
  assign o_push_addr     = i_req_addr;
  assign o_push_wdata    = i_req_wdata;

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      credits <= CREDIT_W'(REQ_FIFO_DEPTH);
    end
    else
    begin
      case ({accept, i_credit})
        2'b10:   credits <= credits - 1'b1;  // spent on a push
        2'b01:   credits <= credits + 1'b1;  // returned by a pop
        default: credits <= credits;         // both or neither
      endcase
    end
  end

endmodule

//--- source/riscv_mem_req_fifo.sv
`timescale 1ns/1ns

module riscv_mem_req_fifo
  import riscv_mem_pkg::*;
(
  input  logic     i_riscv_dm_rst,
  input  logic     i_riscv_dm_clk_n,
  input  logic     i_push,
  input  logic     i_push_store,
  input  dm_size_t i_push_size,
  input  logic     i_push_unsigned,
  input  dm_addr_t i_push_addr,
  input  dm_data_t i_push_wdata,
  input  logic     i_pop,
  output logic     o_not_empty,
  output logic     o_head_store,
  output dm_size_t o_head_size,
  output logic     o_head_unsigned,
  output dm_addr_t o_head_addr,
  output dm_data_t o_head_wdata,
  output logic     o_credit
);

  logic     store_q    [REQ_FIFO_DEPTH];
  dm_size_t size_q     [REQ_FIFO_DEPTH];
  logic     unsigned_q [REQ_FIFO_DEPTH];
  dm_addr_t addr_q     [REQ_FIFO_DEPTH];
  dm_data_t wdata_q    [REQ_FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [CREDIT_W-1:0]   count;
  logic                  do_pop;

  assign o_not_empty = (count != '0);
  assign do_pop      = i_pop && o_not_empty;
  assign o_credit    = do_pop;  // one credit back per pop

  assign o_head_store    = store_q[rd_ptr];
  assign o_head_size     = size_q[rd_ptr];
  assign o_head_unsigned = unsigned_q[rd_ptr];
  assign o_head_addr     = addr_q[rd_ptr];
  assign o_head_wdata    = wdata_q[rd_ptr];

  // producer credits keep pushes off a full buffer
  always_ff @(posedge i_riscv_dm_rst)
  begin
    if (i_push)
    begin
      store_q[wr_ptr]    <= i_push_store;
      size_q[wr_ptr]     <= i_push_size;
      unsigned_q[wr_ptr] <= i_push_unsigned;
      addr_q[wr_ptr]     <= i_push_addr;
      wdata_q[wr_ptr]    <= i_push_wdata;
    end
  end

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (i_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !i_push)
        count <= count - 1'b1;
    end
  end

endmodule

//--- source/riscv_dm.sv
`timescale 1ns/1ns

module riscv_dm
  import riscv_mem_pkg::*;
(
  input  logic     i_riscv_dm_rst,
  input  logic     i_riscv_dm_clk_n,
  input  logic     i_riscv_dm_wen,
  input  dm_size_t i_riscv_dm_sel,
  input  dm_data_t i_riscv_dm_wdata,
  input  dm_addr_t i_riscv_dm_waddr,
  output dm_data_t o_riscv_dm_rdata
);

  dm_byte_t            mem      [DM_BYTES];
  logic [DM_IDX_W-1:0] byte_idx [DM_WORD_BYTES];
  logic [3:0]          nbytes;

  // byte lane indices wrap modulo the memory size
  always_comb
  begin
    for (int k = 0; k < DM_WORD_BYTES; k++)
      byte_idx[k] = i_riscv_dm_waddr[DM_IDX_W-1:0] + DM_IDX_W'(k);
  end

  assign nbytes = 4'd1 << i_riscv_dm_sel;  // 1, 2, 4 or 8 bytes written

  // little-endian read of eight bytes
  always_comb
  begin
    for (int k = 0; k < DM_WORD_BYTES; k++)
      o_riscv_dm_rdata[8*k +: 8] = mem[byte_idx[k]];
  end

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      for (int i = 0; i < DM_BYTES; i++)
        mem[i] <= '0;
    end
    else if (i_riscv_dm_wen)
    begin
      for (int k = 0; k < DM_WORD_BYTES; k++)
      begin
        if (k < nbytes)
          mem[byte_idx[k]] <= i_riscv_dm_wdata[8*k +: 8];
      end
    end
  end

endmodule

//--- source/riscv_mem_ctrl.sv
`timescale 1ns/1ns

module riscv_mem_ctrl
  import riscv_mem_pkg::*;
(
  input  logic     i_riscv_dm_rst,
  input  logic     i_riscv_dm_clk_n,
  input  logic     i_not_empty,
  input  logic     i_head_store,
  input  dm_size_t i_head_size,
  input  logic     i_head_unsigned,
  input  dm_addr_t i_head_addr,
  input  dm_data_t i_head_wdata,
  output logic     o_pop,
  output logic     o_load_valid,
  output dm_data_t o_load_data
);

  ctrl_state_t state;
  logic        req_store;
  dm_size_t    req_size;
  logic        req_unsigned;
  dm_addr_t    req_addr;
  dm_data_t    req_wdata;
  dm_data_t    rdata;
  dm_data_t    load_ext;
  logic        dm_wen;

  assign o_pop  = (state == CTRL_IDLE) && i_not_empty;
  assign dm_wen = (state == CTRL_ACCESS) && req_store;

  riscv_dm dm_i (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_riscv_dm_wen   (dm_wen),
    .i_riscv_dm_sel   (req_size),
    .i_riscv_dm_wdata (req_wdata),
    .i_riscv_dm_waddr (req_addr),
    .o_riscv_dm_rdata (rdata)
  );

  // keep the addressed field, fill above with sign or zero
  always_comb
  begin
    case (req_size)
      DM_SIZE_B: load_ext = {{56{rdata[7] & ~req_unsigned}}, rdata[7:0]};
      DM_SIZE_H: load_ext = {{48{rdata[15] & ~req_unsigned}}, rdata[15:0]};
      DM_SIZE_W: load_ext = {{32{rdata[31] & ~req_unsigned}}, rdata[31:0]};
      default:   load_ext = rdata;  // full double word
    endcase
  end

  // latched request and registered load result
  always_ff @(posedge i_riscv_dm_rst)
  begin
    if (o_pop)
    begin
      req_store    <= i_head_store;
      req_size     <= i_head_size;
      req_unsigned <= i_head_unsigned;
      req_addr     <= i_head_addr;
      req_wdata    <= i_head_wdata;
    end
    if (state == CTRL_ACCESS && !req_store)
      o_load_data <= load_ext;
  end

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      state        <= CTRL_IDLE;
      o_load_valid <= 1'b0;
    end
    else
    begin
      o_load_valid <= 1'b0;  // one-cycle pulse
      case (state)
        CTRL_IDLE:
        begin
          if (i_not_empty)
            state <= CTRL_ACCESS;
        end
        default:
        begin
          o_load_valid <= !req_store;
          state        <= CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

//--- source/riscv_mem_stage.sv
`timescale 1ns/1ns

module riscv_mem_stage
  import riscv_mem_pkg::*;
(
  input  logic        i_riscv_dm_rst,
  input  logic        i_riscv_dm_clk_n,
  input  logic        i_req_valid,
  input  logic        i_req_store,
  input  mem_funct3_t i_req_funct3,
  input  dm_addr_t    i_req_addr,
  input  dm_data_t    i_req_wdata,
  output logic        o_req_ready,
  output logic        o_load_valid,
  output dm_data_t    o_load_data
);

  // producer to fifo
  logic     push;
  logic     push_store;
  dm_size_t push_size;
  logic     push_unsigned;
  dm_addr_t push_addr;
  dm_data_t push_wdata;
  logic     credit;

  // fifo to controller
  logic     pop;
  logic     not_empty;
  logic     head_store;
  dm_size_t head_size;
  logic     head_unsigned;
  dm_addr_t head_addr;
  dm_data_t head_wdata;

  riscv_lsu_req lsu_req_i (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_req_valid      (i_req_valid),
    .i_req_store      (i_req_store),
    .i_req_funct3     (i_req_funct3),
    .i_req_addr       (i_req_addr),
    .i_req_wdata      (i_req_wdata),
    .i_credit         (credit),
    .o_req_ready      (o_req_ready),
    .o_push           (push),
    .o_push_store     (push_store),
    .o_push_size      (push_size),
    .o_push_unsigned  (push_unsigned),
    .o_push_addr      (push_addr),
    .o_push_wdata     (push_wdata)
  );

  riscv_mem_req_fifo req_fifo_i (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_push           (push),
    .i_push_store     (push_store),
    .i_push_size      (push_size),
    .i_push_unsigned  (push_unsigned),
    .i_push_addr      (push_addr),
    .i_push_wdata     (push_wdata),
    .i_pop            (pop),
    .o_not_empty      (not_empty),
    .o_head_store     (head_store),
    .o_head_size      (head_size),
    .o_head_unsigned  (head_unsigned),
    .o_head_addr      (head_addr),
    .o_head_wdata     (head_wdata),
    .o_credit         (credit)
  );

  riscv_mem_ctrl mem_ctrl_i (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_not_empty      (not_empty),
    .i_head_store     (head_store),
    .i_head_size      (head_size),
    .i_head_unsigned  (head_unsigned),
    .i_head_addr      (head_addr),
    .i_head_wdata     (head_wdata),
    .o_pop            (pop),
    .o_load_valid     (o_load_valid),
    .o_load_data      (o_load_data)
  );

endmodule

//--- verification/riscv_mem_stage_assertions.sv
`timescale 1ns/1ns

module riscv_mem_stage_assertions
  import riscv_mem_pkg::*;
(
  input logic                i_riscv_dm_rst,
  input logic                i_riscv_dm_clk_n,
  input logic [CREDIT_W-1:0] i_credits,
  input logic                i_pop,
  input logic                i_load_valid
);

  int fail_count = 0;

  credits_bounded: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    i_credits <= CREDIT_W'(REQ_FIFO_DEPTH))
    else
    begin
      $error("credit count above fifo depth");
      fail_count++;
    end

  // all credits home means the fifo holds nothing
  pop_needs_entry: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    i_pop |-> i_credits != CREDIT_W'(REQ_FIFO_DEPTH))
    else
    begin
      $error("pop while request fifo is empty");
      fail_count++;
    end

  // controller needs two cycles per request
  load_valid_pulse: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    i_load_valid |=> !i_load_valid)
    else
    begin
      $error("load valid high in two consecutive cycles");
      fail_count++;
    end

endmodule

bind riscv_mem_stage riscv_mem_stage_assertions assertions_i (
  .i_riscv_dm_rst   (i_riscv_dm_rst),
  .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
  .i_credits        (lsu_req_i.credits),
  .i_pop            (pop),
  .i_load_valid     (o_load_valid)
);

//--- verification/riscv_mem_stage_tb.sv
`timescale 1ns/1ns

module riscv_mem_stage_tb
  import riscv_mem_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_OPS         = 84;  // requests issued over all tests
  localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + 200;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_store;
  mem_funct3_t req_funct3;
  dm_addr_t    req_addr;
  dm_data_t    req_wdata;
  logic        req_ready;
  logic        load_valid;
  dm_data_t    load_data;

  dm_byte_t ref_mem [DM_BYTES];  // reference copy of the data memory
  dm_data_t exp_q [$];           // expected load results in order
  integer   seed = 32'ha0c84927;
  int       err_count = 0;
  int       check_count = 0;
  bit       stall_seen;

  riscv_mem_stage dut_i (
    .i_riscv_dm_rst   (clk),
    .i_riscv_dm_clk_n (rst_n),
    .i_req_valid      (req_valid),
    .i_req_store      (req_store),
    .i_req_funct3     (req_funct3),
    .i_req_addr       (req_addr),
    .i_req_wdata      (req_wdata),
    .o_req_ready      (req_ready),
    .o_load_valid     (load_valid),
    .o_load_data      (load_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0t, the run did not complete", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_data(input string name, input dm_data_t exp, input dm_data_t act);
    check_count++;
    if (act !== exp)
    begin
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_ready(input string name, input bit exp, input bit act);
    check_count++;
    if (act !== exp)
    begin
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  function automatic void model_write(input mem_funct3_t f3, input dm_addr_t addr,
                                      input dm_data_t data);
    int nbytes;
    nbytes = 1 << f3[1:0];
    for (int k = 0; k < nbytes; k++)
      ref_mem[(int'(addr[4:0]) + k) % DM_BYTES] = data[8*k +: 8];  // wraps at the top
  endfunction

  function automatic dm_data_t expected_load(input mem_funct3_t f3, input dm_addr_t addr);
    dm_data_t val;
    int       nbytes;
    logic     sign;
    val    = '0;
    nbytes = 1 << f3[1:0];
    for (int k = 0; k < nbytes; k++)
      val[8*k +: 8] = ref_mem[(int'(addr[4:0]) + k) % DM_BYTES];
    sign = val[8*nbytes-1] & ~f3[2];  // bit 2 means zero extension
    for (int b = 8 * nbytes; b < 64; b++)
      val[b] = sign;
    return val;
  endfunction

  // starts at a falling edge and ends one falling edge after acceptance
  task automatic issue(input logic store, input mem_funct3_t f3, input dm_addr_t addr,
                       input dm_data_t wdata);
    req_valid  = 1'b1;
    req_store  = store;
    req_funct3 = f3;
    req_addr   = addr;
    req_wdata  = wdata;
    while (!req_ready)
    begin
      stall_seen = 1'b1;
      @(negedge clk);
    end
    if (store)
      model_write(f3, addr, wdata);
    else
      exp_q.push_back(expected_load(f3, addr));
    @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    waited    = 0;
    req_valid = 1'b0;
    while (exp_q.size() != 0 && waited < 64)
    begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("%0d expected load results still missing at %0t", exp_q.size(), $time);
      err_count++;
      exp_q.delete();
    end
    repeat (2) @(negedge clk);  // let a trailing store land
  endtask

  // load results compared mid-cycle
  always @(negedge clk)
  begin
    if (rst_n && load_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("load result %h arrived at %0t with no load outstanding", load_data, $time);
        err_count++;
      end
      else
        check_data("o_load_data", exp_q.pop_front(), load_data);
    end
  end

  task automatic test_reset_state();
    check_ready("o_req_ready", 1'b1, req_ready);
    check_count++;
    if (load_valid !== 1'b0)
    begin
      $display("error at %0t: o_load_valid expected 0, got %b", $time, load_valid);
      err_count++;
    end
    for (int a = 0; a < DM_BYTES; a += 8)
      issue(1'b0, F3_D, dm_addr_t'(a), '0);
    drain();
  endtask

  task automatic test_extend();
    dm_data_t pats [2];
    pats[0] = 64'hf0e1d2c3_b4a59687;  // top bit set in every field
    pats[1] = 64'h0f1e2d3c_4b5a6978;  // top bit clear
    for (int p = 0; p < 2; p++)
    begin
      issue(1'b1, F3_D, dm_addr_t'(8 + 8 * p), pats[p]);
      for (int f = 0; f < 7; f++)
        issue(1'b0, mem_funct3_t'(f), dm_addr_t'(8 + 8 * p), '0);
    end
    drain();
  endtask

  task automatic test_partial_store();
    issue(1'b1, F3_D, 64'd16, 64'h11223344_55667788);
    issue(1'b1, F3_B, 64'd17, 64'hffffffff_ffffffaa);
    issue(1'b1, F3_H, 64'd18, 64'heeeeeeee_eeeebbcc);
    issue(1'b1, F3_W, 64'd20, 64'hdddddddd_01234567);
    issue(1'b0, F3_D, 64'd16, '0);
    issue(1'b0, F3_D, 64'd24, '0);  // neighbour untouched
    drain();
  endtask

  task automatic test_wrap();
    issue(1'b1, F3_W, 64'd30, 64'h00000000_a1b2c3d4);
    issue(1'b0, F3_W, 64'd30, '0);
    issue(1'b0, F3_WU, 64'd0, '0);
    issue(1'b1, F3_D, 64'd28, 64'h88776655_44332211);
    issue(1'b0, F3_D, 64'd28, '0);
    issue(1'b0, F3_W, 64'd0, '0);
    drain();
  endtask

  task automatic test_back_to_back();
    dm_addr_t addr;
    stall_seen = 1'b0;
    for (int i = 0; i < 12; i++)
    begin
      addr = dm_addr_t'(8 * ((i / 2) % 4));
      if (i % 2 == 0)
        issue(1'b1, F3_D, addr, {$random(seed), $random(seed)});
      else
        issue(1'b0, F3_D, addr, '0);
    end
    drain();
    if (!stall_seen)
    begin
      $display("o_req_ready never dropped during back-to-back requests");
      err_count++;
    end
    check_ready("o_req_ready", 1'b1, req_ready);
  endtask

  task automatic test_random();
    logic        store;
    mem_funct3_t f3;
    dm_addr_t    addr;
    dm_data_t    data;
    for (int n = 0; n < 40; n++)
    begin
      store = ($random(seed) & 1) != 0;
      if (store)
        f3 = mem_funct3_t'($unsigned($random(seed)) % 4);
      else
        f3 = mem_funct3_t'($unsigned($random(seed)) % 7);
      addr = dm_addr_t'($unsigned($random(seed)) % DM_BYTES);
      data = {$random(seed), $random(seed)};
      issue(store, f3, addr, data);
    end
    drain();
  endtask

  initial
  begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_store  = 1'b0;
    req_funct3 = F3_B;
    req_addr   = '0;
    req_wdata  = '0;
    stall_seen = 1'b0;
    for (int i = 0; i < DM_BYTES; i++)
      ref_mem[i] = '0;  // memory is cleared by reset
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_extend();
    test_partial_store();
    test_wrap();
    test_back_to_back();
    test_random();
    err_count += dut_i.assertions_i.fail_count;  // bound assertion failures
    $display("errors: %0d, checks: %0d", err_count, check_count);
    if (err_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- vlog.f
source/riscv_mem_pkg.sv
source/riscv_lsu_req.sv
source/riscv_mem_req_fifo.sv
source/riscv_dm.sv
source/riscv_mem_ctrl.sv
source/riscv_mem_stage.sv
verification/riscv_mem_stage_assertions.sv
verification/riscv_mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_mem_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
